/* hdl/hazard_config.svh */
// Widths, register numbers and stage count shared by the hazard logic
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// Full instruction word
`define INSTR_W 16

// Opcode field, top bits of the word
`define OPCODE_W 4

// Register address field, 16 registers
`define REG_W 4

// Data segment register, read by ld and st in place of rs
`define DATA_SEG_REG 14

// Stages tracked after IF/ID: ID/EX, EX/MEM, MEM/WB
`define NUM_STAGES 3

`endif

/* hdl/isa_pkg.sv */
// Instruction set types, field layout and opcode class helpers
`include "hazard_config.svh"

package isa_pkg;

    typedef logic [`INSTR_W-1:0] instr_t;
    typedef logic [`REG_W-1:0]   reg_addr_t;

    // Opcodes 10 and 11 are unassigned
    typedef enum logic [`OPCODE_W-1:0] {
        OP_ADD  = 0,
        OP_SUB  = 1,
        OP_AND  = 2,
        OP_OR   = 3,
        OP_XOR  = 4,
        OP_SHL  = 5,
        OP_SHR  = 6,
        OP_ADDI = 7,
        OP_LD   = 8,
        OP_ST   = 9,
        OP_BR   = 12,
        OP_CALL = 13,
        OP_RET  = 14,
        OP_NOP  = 15
    } opcode_t;

    // Word layout: opcode, rd, rs, rt from the top down
    localparam int OPC_LSB = `INSTR_W - `OPCODE_W;
    localparam int RD_LSB  = OPC_LSB - `REG_W;
    localparam int RS_LSB  = RD_LSB - `REG_W;
    localparam int RT_LSB  = RS_LSB - `REG_W;

    function automatic opcode_t instr_opcode(instr_t word);
        return opcode_t'(word[OPC_LSB +: `OPCODE_W]);
    endfunction

    function automatic reg_addr_t instr_rd(instr_t word);
        return word[RD_LSB +: `REG_W];
    endfunction

    function automatic reg_addr_t instr_rs(instr_t word);
        return word[RS_LSB +: `REG_W];
    endfunction

    function automatic reg_addr_t instr_rt(instr_t word);
        return word[RT_LSB +: `REG_W];
    endfunction

    // Result goes back to rd
    function automatic logic writes_rd(opcode_t op);
        return !(op inside {OP_ST, OP_BR, OP_CALL, OP_RET, OP_NOP});
    endfunction

    // Memory ops address through the data segment register
    function automatic logic uses_data_seg(opcode_t op);
        return op inside {OP_LD, OP_ST};
    endfunction

    // Changes the fetch stream, fetch blocked until retirement
    function automatic logic is_redirect(opcode_t op);
        return op inside {OP_BR, OP_RET};
    endfunction

    // Never held for register dependencies
    function automatic logic no_data_check(opcode_t op);
        return op inside {OP_CALL, OP_RET};
    endfunction

endpackage

/* hdl/pipe_pkg.sv */
// Pipeline state types: stage indices, stage masks and slot records
`include "hazard_config.svh"

package pipe_pkg;

    // Stage index, ID/EX is youngest
    typedef logic [$clog2(`NUM_STAGES)-1:0] stage_idx_t;

    localparam stage_idx_t STG_ID_EX  = 0;
    localparam stage_idx_t STG_EX_MEM = 1;
    localparam stage_idx_t STG_MEM_WB = 2;

    // One flag per tracked stage
    typedef logic [`NUM_STAGES-1:0] stage_mask_t;

    // What a stage carries besides its valid bit
    typedef struct packed {
        isa_pkg::opcode_t   opcode;
        isa_pkg::reg_addr_t rd;
        logic               wr;
    } slot_t;

endpackage

/* hdl/instr_decode.sv */
// Fetch handshake, IF/ID register, field decode and issue toward the tracker
`timescale 1ns/1ps
`include "hazard_config.svh"

module instr_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  isa_pkg::instr_t    instr_word,
    input  logic               fetch_hold,
    input  logic               data_hazard,
    output logic               instr_ack,
    output logic               if_full,
    output isa_pkg::opcode_t   if_opcode,
    output isa_pkg::reg_addr_t if_rs,
    output isa_pkg::reg_addr_t if_rt,
    output isa_pkg::reg_addr_t if_rd,
    output logic               issue_valid,
    output isa_pkg::opcode_t   issue_opcode,
    output isa_pkg::reg_addr_t issue_rd,
    output logic               issue_wr
);
    import isa_pkg::*;

    // IF/ID payload
    instr_t if_word;
    logic   capture;

    // New request, IF/ID free, fetch not blocked by a redirect
    assign capture = instr_req && !instr_ack && !if_full && !fetch_hold;

    // Four-phase ack
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack <= 1'b0;
        end else if (capture) begin
            instr_ack <= 1'b1;
        end else if (!instr_req) begin
            // Req seen low, return to zero
            instr_ack <= 1'b0;
        end
    end

    // IF/ID occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            if_full <= 1'b0;
        end else if (capture) begin
            if_full <= 1'b1;
        end else if (issue_valid) begin
            if_full <= 1'b0;
        end
    end

    // Word captured with the ack rise
    always_ff @(posedge clk) begin
        if (capture) begin
            if_word <= instr_word;
        end
    end

    // Field decode
    assign if_opcode = instr_opcode(if_word);
    assign if_rd     = instr_rd(if_word);
    assign if_rs     = instr_rs(if_word);
    assign if_rt     = instr_rt(if_word);

    // Issue as soon as the hazard unit lets it go
    assign issue_valid  = if_full && !data_hazard;
    assign issue_opcode = if_opcode;
    assign issue_rd     = if_rd;
    // Only writers block later readers
    assign issue_wr     = writes_rd(if_opcode);

endmodule

/* hdl/hazard_unit.sv */
// Register-match data hazard and fetch hold for branch and return
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 if_full,
    input  isa_pkg::opcode_t                     if_opcode,
    input  isa_pkg::reg_addr_t                   if_rs,
    input  isa_pkg::reg_addr_t                   if_rt,
    input  isa_pkg::reg_addr_t                   if_rd,
    input  pipe_pkg::stage_mask_t                stage_valid,
    input  isa_pkg::reg_addr_t [`NUM_STAGES-1:0] stage_rd,
    input  pipe_pkg::stage_mask_t                stage_wr,
    input  pipe_pkg::stage_mask_t                stage_redirect,
    input  logic                                 issue_valid,
    input  isa_pkg::opcode_t                     issue_opcode,
    input  logic                                 tracker_retired,
    input  logic                                 tracker_frozen,
    output logic                                 data_hazard,
    output logic                                 fetch_hold
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // First read port, rs or the data segment register
    reg_addr_t   read_rs;
    // Per-stage destination hits
    stage_mask_t stage_hit;
    logic        reg_match;

    assign read_rs = uses_data_seg(if_opcode) ? reg_addr_t'(`DATA_SEG_REG) : if_rs;

    // Compare all three reads against every valid writer
    always_comb begin
        for (int i = 0; i < `NUM_STAGES; i++) begin
            stage_hit[i] = stage_valid[i] && stage_wr[i] &&
                           ((stage_rd[i] == read_rs) ||
                            (stage_rd[i] == if_rt) ||
                            (stage_rd[i] == if_rd));
        end
    end

    // Call and return skip the match
    assign reg_match = (|stage_hit) && !no_data_check(if_opcode);

    // Frozen tail cannot take an issue either
    assign data_hazard = if_full && (tracker_frozen || reg_match);

    // Held from the cycle after a redirect issues until it retires
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold <= 1'b0;
        end else if (issue_valid && is_redirect(issue_opcode)) begin
            fetch_hold <= 1'b1;
        end else if (tracker_retired && stage_redirect[STG_MEM_WB]) begin
            // The redirect leaves MEM/WB on this edge
            fetch_hold <= 1'b0;
        end
    end

endmodule

/* hdl/pipe_dest_tracker.sv */
// In-flight destination records for ID/EX, EX/MEM and MEM/WB
`timescale 1ns/1ps
`include "hazard_config.svh"

module pipe_dest_tracker (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  isa_pkg::opcode_t                     issue_opcode,
    input  isa_pkg::reg_addr_t                   issue_rd,
    input  logic                                 issue_wr,
    input  logic                                 retire_done,
    output pipe_pkg::stage_mask_t                stage_valid,
    output isa_pkg::reg_addr_t [`NUM_STAGES-1:0] stage_rd,
    output pipe_pkg::stage_mask_t                stage_wr,
    output pipe_pkg::stage_mask_t                stage_redirect,
    output isa_pkg::opcode_t                     mw_opcode,
    output logic                                 tracker_retired,
    output logic                                 tracker_frozen
);
    import isa_pkg::*;
    import pipe_pkg::*;

    stage_mask_t vld;
    slot_t       slot [`NUM_STAGES];
    // Record entering ID/EX
    slot_t       entry;
    logic        advance;

    // Move on when MEM/WB is empty or leaving this cycle
    assign advance         = !vld[STG_MEM_WB] || retire_done;
    assign tracker_frozen  = !advance;
    assign tracker_retired = vld[STG_MEM_WB] && retire_done;

    assign entry.opcode = issue_opcode;
    assign entry.rd     = issue_rd;
    assign entry.wr     = issue_wr;

    // Valid bits, a bubble enters when nothing issues
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[`NUM_STAGES-2:0], issue_valid};
        end
    end

    // Records shift with the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            slot[STG_ID_EX]  <= entry;
            slot[STG_EX_MEM] <= slot[STG_ID_EX];
            slot[STG_MEM_WB] <= slot[STG_EX_MEM];
        end
    end

    assign stage_valid = vld;

    always_comb begin
        for (int i = 0; i < `NUM_STAGES; i++) begin
            stage_rd[i]       = slot[i].rd;
            stage_wr[i]       = slot[i].wr;
            stage_redirect[i] = is_redirect(slot[i].opcode);
        end
    end

    // Oldest entry toward the retire port
    assign mw_opcode = slot[STG_MEM_WB].opcode;

endmodule

/* hdl/retire_port.sv */
// Four-phase retire handshake for the MEM/WB entry
`timescale 1ns/1ps

module retire_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               mw_valid,
    input  isa_pkg::opcode_t   mw_opcode,
    input  isa_pkg::reg_addr_t mw_rd,
    input  logic               retire_ack,
    output logic               retire_req,
    output isa_pkg::opcode_t   retire_opcode,
    output isa_pkg::reg_addr_t retire_rd,
    output logic               retire_done
);

    typedef enum logic [1:0] {
        RT_IDLE,
        RT_REQ,
        // Done, waiting for ack to return to zero
        RT_WAIT_LOW
    } rt_state_t;

    rt_state_t state;
    logic      load;

    // New entry offered once the previous cycle has fully closed
    assign load = mw_valid &&
                  ((state == RT_IDLE) || ((state == RT_WAIT_LOW) && !retire_ack));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RT_IDLE;
        end else begin
            case (state)
                RT_IDLE: begin
                    if (load) state <= RT_REQ;
                end
                RT_REQ: begin
                    if (retire_ack) state <= RT_WAIT_LOW;
                end
                RT_WAIT_LOW: begin
                    if (load) begin
                        state <= RT_REQ;
                    end else if (!retire_ack) begin
                        state <= RT_IDLE;
                    end
                end
                default: state <= RT_IDLE;
            endcase
        end
    end

    // Data held still for the whole request
    always_ff @(posedge clk) begin
        if (load) begin
            retire_opcode <= mw_opcode;
            retire_rd     <= mw_rd;
        end
    end

    assign retire_req  = (state == RT_REQ);
    // MEM/WB frees on this edge
    assign retire_done = (state == RT_REQ) && retire_ack;

endmodule

/* hdl/hazard_top.sv */
// Issue-side hazard logic: decode, hazard check, stage tracking and retire
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  isa_pkg::instr_t    instr_word,
    input  logic               retire_ack,
    output logic               instr_ack,
    output logic               issue_valid,
    output isa_pkg::opcode_t   issue_opcode,
    output isa_pkg::reg_addr_t issue_rd,
    output logic               fetch_hold,
    output logic               retire_req,
    output isa_pkg::opcode_t   retire_opcode,
    output isa_pkg::reg_addr_t retire_rd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // IF/ID fields toward the hazard unit
    logic      if_full;
    opcode_t   if_opcode;
    reg_addr_t if_rs;
    reg_addr_t if_rt;
    reg_addr_t if_rd;
    logic      issue_wr;
    logic      data_hazard;

    // Stage state
    stage_mask_t                     stage_valid;
    reg_addr_t [`NUM_STAGES-1:0]     stage_rd;
    stage_mask_t                     stage_wr;
    stage_mask_t                     stage_redirect;
    opcode_t                         mw_opcode;
    logic                            tracker_retired;
    logic                            tracker_frozen;
    logic                            retire_done;

    instr_decode u_instr_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_req    (instr_req),
        .instr_word   (instr_word),
        .fetch_hold   (fetch_hold),
        .data_hazard  (data_hazard),
        .instr_ack    (instr_ack),
        .if_full      (if_full),
        .if_opcode    (if_opcode),
        .if_rs        (if_rs),
        .if_rt        (if_rt),
        .if_rd        (if_rd),
        .issue_valid  (issue_valid),
        .issue_opcode (issue_opcode),
        .issue_rd     (issue_rd),
        .issue_wr     (issue_wr)
    );

    hazard_unit u_hazard_unit (
        .clk             (clk),
        .rst             (rst),
        .if_full         (if_full),
        .if_opcode       (if_opcode),
        .if_rs           (if_rs),
        .if_rt           (if_rt),
        .if_rd           (if_rd),
        .stage_valid     (stage_valid),
        .stage_rd        (stage_rd),
        .stage_wr        (stage_wr),
        .stage_redirect  (stage_redirect),
        .issue_valid     (issue_valid),
        .issue_opcode    (issue_opcode),
        .tracker_retired (tracker_retired),
        .tracker_frozen  (tracker_frozen),
        .data_hazard     (data_hazard),
        .fetch_hold      (fetch_hold)
    );

    pipe_dest_tracker u_pipe_dest_tracker (
        .clk             (clk),
        .rst             (rst),
        .issue_valid     (issue_valid),
        .issue_opcode    (issue_opcode),
        .issue_rd        (issue_rd),
        .issue_wr        (issue_wr),
        .retire_done     (retire_done),
        .stage_valid     (stage_valid),
        .stage_rd        (stage_rd),
        .stage_wr        (stage_wr),
        .stage_redirect  (stage_redirect),
        .mw_opcode       (mw_opcode),
        .tracker_retired (tracker_retired),
        .tracker_frozen  (tracker_frozen)
    );

    // MEM/WB slot feeds the retire side
    retire_port u_retire_port (
        .clk           (clk),
        .rst           (rst),
        .mw_valid      (stage_valid[STG_MEM_WB]),
        .mw_opcode     (mw_opcode),
        .mw_rd         (stage_rd[STG_MEM_WB]),
        .retire_ack    (retire_ack),
        .retire_req    (retire_req),
        .retire_opcode (retire_opcode),
        .retire_rd     (retire_rd),
        .retire_done   (retire_done)
    );

endmodule

/* sim/hazard_checker.sv */
// Concurrent assertions on the fetch and retire handshakes of the hazard tail
`timescale 1ns/1ps

module hazard_checker (
    input logic               clk,
    input logic               rst,
    input logic               instr_req,
    input logic               instr_ack,
    input logic               retire_req,
    input logic               retire_ack,
    input isa_pkg::opcode_t   retire_opcode,
    input isa_pkg::reg_addr_t retire_rd
);

    // Failed assertions, read by the testbench for its closing line
    int assert_errors = 0;

    // Ack only answers a live request
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(instr_ack) |-> $past(instr_req)
    ) else begin
        assert_errors++;
        $error("instr_ack rose without instr_req high");
    end

    // Request and its data hold until the consumer answers
    retire_req_held: assert property (
        @(posedge clk) disable iff (rst)
        retire_req && !retire_ack |=>
            retire_req && $stable(retire_opcode) && $stable(retire_rd)
    ) else begin
        assert_errors++;
        $error("retire_req or its data changed before retire_ack");
    end

    // Return to zero before the next request
    retire_no_rerise: assert property (
        @(posedge clk) disable iff (rst)
        retire_ack && !retire_req |=> !retire_req
    ) else begin
        assert_errors++;
        $error("retire_req rose while retire_ack was still high");
    end

endmodule

/* sim/hazard_monitor.sv */
// Reference model of the hazard tail, compared against the DUT ports every edge
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_monitor (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::instr_t    instr_word,
    input  logic               instr_ack,
    input  logic               issue_valid,
    input  isa_pkg::opcode_t   issue_opcode,
    input  isa_pkg::reg_addr_t issue_rd,
    input  logic               fetch_hold,
    input  logic               retire_req,
    input  logic               retire_ack,
    input  isa_pkg::opcode_t   retire_opcode,
    input  isa_pkg::reg_addr_t retire_rd,
    output int                 accepted_count,
    output int                 retired_count,
    output int                 check_count,
    output int                 error_count
);
    import isa_pkg::*;

    // Accepted, waiting to issue
    instr_t    issue_queue [$];
    // Accepted, waiting to retire
    instr_t    retire_queue [$];
    // Issued and not yet retired, oldest first
    reg_addr_t flight_rd [$];
    logic      flight_wr [$];

    instr_t    expected;
    instr_t    prev_word;
    logic      prev_ack;
    logic      prev_hold;
    logic      model_hold;
    logic      hold_set;
    logic      hold_clear;
    reg_addr_t read_a;
    int        accepted;
    int        retired;
    int        checks;
    int        errors;

    // Opcode classes, straight from the instruction set description
    function automatic logic writes_dest(opcode_t op);
        return !(op inside {OP_ST, OP_BR, OP_CALL, OP_RET, OP_NOP});
    endfunction

    function automatic logic reads_segment(opcode_t op);
        return op inside {OP_LD, OP_ST};
    endfunction

    function automatic logic stalls_fetch(opcode_t op);
        return op inside {OP_BR, OP_RET};
    endfunction

    function automatic logic skips_hazard(opcode_t op);
        return op inside {OP_CALL, OP_RET};
    endfunction

    task automatic report_mismatch(string name, int got, int exp);
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // Word layout is opcode, rd, rs, rt from the top
    always @(posedge clk) begin
        if (rst) begin
            issue_queue.delete();
            retire_queue.delete();
            flight_rd.delete();
            flight_wr.delete();
            model_hold = 1'b0;
            prev_ack   = 1'b0;
            prev_hold  = 1'b0;
            accepted   = 0;
            retired    = 0;
            checks     = 0;
            errors     = 0;
        end else begin
            hold_set   = 1'b0;
            hold_clear = 1'b0;
            checks++;
            if (fetch_hold !== model_hold)
                report_mismatch("fetch_hold", fetch_hold, model_hold);

            // Ack rise means the word on the previous edge was captured
            if (instr_ack && !prev_ack) begin
                if (prev_hold)
                    report_failure("instr_ack rose while fetch_hold was high");
                issue_queue.push_back(prev_word);
                retire_queue.push_back(prev_word);
                accepted++;
            end

            if (issue_valid) begin
                if (issue_queue.size() == 0) begin
                    report_failure("issue_valid with no accepted instruction waiting");
                end else begin
                    expected = issue_queue.pop_front();
                    checks++;
                    if (issue_opcode !== opcode_t'(expected[15:12]))
                        report_mismatch("issue_opcode", issue_opcode, expected[15:12]);
                    if (issue_rd !== expected[11:8])
                        report_mismatch("issue_rd", issue_rd, expected[11:8]);
                    // Loads and stores read the data segment register instead of rs
                    read_a = reads_segment(opcode_t'(expected[15:12])) ?
                             reg_addr_t'(`DATA_SEG_REG) : expected[7:4];
                    if (!skips_hazard(opcode_t'(expected[15:12]))) begin
                        for (int i = 0; i < flight_rd.size(); i++) begin
                            if (flight_wr[i] && (flight_rd[i] == read_a ||
                                flight_rd[i] == expected[3:0] ||
                                flight_rd[i] == expected[11:8]))
                                report_failure($sformatf(
                                    "issued over an in-flight writer of r%0d", flight_rd[i]));
                        end
                    end
                    flight_rd.push_back(expected[11:8]);
                    flight_wr.push_back(writes_dest(opcode_t'(expected[15:12])));
                    hold_set = stalls_fetch(opcode_t'(expected[15:12]));
                end
            end

            // Retirement completes on req and ack both high
            if (retire_req && retire_ack) begin
                if (retire_queue.size() == 0 || flight_rd.size() == 0) begin
                    report_failure("retirement with no instruction in flight");
                end else begin
                    expected = retire_queue.pop_front();
                    void'(flight_rd.pop_front());
                    void'(flight_wr.pop_front());
                    retired++;
                    checks++;
                    if (retire_opcode !== opcode_t'(expected[15:12]))
                        report_mismatch("retire_opcode", retire_opcode, expected[15:12]);
                    if (retire_rd !== expected[11:8])
                        report_mismatch("retire_rd", retire_rd, expected[11:8]);
                    hold_clear = stalls_fetch(opcode_t'(expected[15:12]));
                end
            end

            if (hold_set)
                model_hold = 1'b1;
            else if (hold_clear)
                model_hold = 1'b0;
            prev_ack  = instr_ack;
            prev_word = instr_word;
            prev_hold = fetch_hold;
        end
        accepted_count <= accepted;
        retired_count  <= retired;
        check_count    <= checks;
        error_count    <= errors;
    end

endmodule

/* sim/hazard_tb.sv */
// Testbench for the hazard tail with fetch and retire agents and a reference monitor
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_tb;
    import isa_pkg::*;

    localparam int          NUM_INSTR      = 300;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 40;
    // IF/ID plus every tracked stage may still be draining after the last accept
    localparam int          DRAIN_CYCLES   = (`NUM_STAGES + 1) * 40;
    localparam logic [31:0] SEED           = 32'd54956;

    // Valid opcodes only, 10 and 11 are unassigned
    localparam opcode_t OPCODE_SET [14] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SHL, OP_SHR, OP_ADDI, OP_LD, OP_ST, OP_BR, OP_CALL, OP_RET, OP_NOP};
    // Small hot set so that dependencies are frequent
    localparam reg_addr_t HOT_REGS [4] = '{4'd1, 4'd2, 4'd3, 4'(`DATA_SEG_REG)};

    logic        clk;
    logic        rst;
    logic        instr_req;
    instr_t      instr_word;
    logic        retire_ack;
    logic        instr_ack;
    logic        issue_valid;
    opcode_t     issue_opcode;
    reg_addr_t   issue_rd;
    logic        fetch_hold;
    logic        retire_req;
    opcode_t     retire_opcode;
    reg_addr_t   retire_rd;

    int          accepted_count;
    int          retired_count;
    int          check_count;
    int          error_count;
    int          end_errors;
    int          assert_errors;
    int          cycle_count;
    logic [31:0] fetch_state;
    logic [31:0] retire_state;

    hazard_top u_hazard_top (.*);

    bind hazard_top hazard_checker u_hazard_checker (
        .clk           (clk),
        .rst           (rst),
        .instr_req     (instr_req),
        .instr_ack     (instr_ack),
        .retire_req    (retire_req),
        .retire_ack    (retire_ack),
        .retire_opcode (retire_opcode),
        .retire_rd     (retire_rd)
    );

    hazard_monitor u_hazard_monitor (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Separate streams so the agents never race for draws
    function automatic logic [15:0] fetch_rand();
        fetch_state = lcg_step(fetch_state);
        return fetch_state[31:16];
    endfunction

    function automatic logic [15:0] retire_rand();
        retire_state = lcg_step(retire_state);
        return retire_state[31:16];
    endfunction

    // Three draws in four come from the hot set
    function automatic reg_addr_t pick_reg();
        logic [15:0] r;
        r = fetch_rand();
        if (r[1:0] != 2'd0)
            return HOT_REGS[r[3:2]];
        else
            return reg_addr_t'(r[7:4]);
    endfunction

    function automatic instr_t make_word();
        logic [15:0] r;
        opcode_t     op;
        reg_addr_t   rd;
        reg_addr_t   rs;
        reg_addr_t   rt;
        r  = fetch_rand();
        op = OPCODE_SET[r % 14];
        rd = pick_reg();
        rs = pick_reg();
        rt = pick_reg();
        return {op, rd, rs, rt};
    endfunction

    task automatic wait_for_ack(input logic level);
        do begin
            @(posedge clk);
        end while (instr_ack !== level);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fetch agent and closing report
    initial begin
        int gap;
        int drain;
        rst          = 1'b1;
        instr_req    = 1'b0;
        instr_word   = '0;
        retire_ack   = 1'b0;
        fetch_state  = SEED;
        retire_state = SEED;
        end_errors   = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            gap = fetch_rand() % 4;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            instr_word <= make_word();
            instr_req  <= 1'b1;
            wait_for_ack(1'b1);
            instr_req <= 1'b0;
            wait_for_ack(1'b0);
        end
        // Let the tail drain through the retire port
        drain = 0;
        while (retired_count < NUM_INSTR && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);

        if (accepted_count != NUM_INSTR) begin
            end_errors++;
            $display("error: only %0d of %0d instructions were accepted",
                     accepted_count, NUM_INSTR);
        end
        if (retired_count != accepted_count) begin
            end_errors++;
            $display("error: %0d accepted instructions never retired",
                     accepted_count - retired_count);
        end
        assert_errors = u_hazard_top.u_hazard_checker.assert_errors;
        $display("checks %0d, monitor errors %0d, assertion errors %0d, end errors %0d",
                 check_count, error_count, assert_errors, end_errors);
        if (error_count == 0 && assert_errors == 0 && end_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Retire agent, random ack delay in both phases
    initial begin
        int delay;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            if (retire_req && !retire_ack) begin
                delay = retire_rand() % 8;
                repeat (delay) @(posedge clk);
                retire_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (retire_req);
                delay = retire_rand() % 4;
                repeat (delay) @(posedge clk);
                retire_ack <= 1'b0;
            end
        end
    end

    // Cycle limit for the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d instructions retired",
                 cycle_count, retired_count, NUM_INSTR);
        $display("test failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/instr_decode.sv
hdl/hazard_unit.sv
hdl/pipe_dest_tracker.sv
hdl/retire_port.sv
hdl/hazard_top.sv
sim/hazard_checker.sv
sim/hazard_monitor.sv
sim/hazard_tb.sv
